/* hdl/opc5_cpu_pkg.sv */
package opc5_cpu_pkg;

   localparam int WORD_BITS     = 16;
   localparam int MEM_WORDS     = 4096;
   localparam int ADDR_BITS     = $clog2(MEM_WORDS);  // Index width into the memory array.
   localparam int REG_ADDR_BITS = 4;
   localparam int REG_COUNT     = 15;                 // Registers r0 to r14 are stored.

   typedef logic [WORD_BITS-1:0]     word_t;
   typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;

   localparam reg_addr_t PC_REG = 4'd15;               // Reads of r15 return the PC.

   typedef enum logic [2:0] {
      FETCH0 = 3'd0,
      FETCH1 = 3'd1,
      EA_ED  = 3'd2,
      RDMEM  = 3'd3,
      EXEC   = 3'd4,
      WRMEM  = 3'd5
   } state_t;

endpackage

/* hdl/opc5_isa_pkg.sv */
package opc5_isa_pkg;

   // The encoding order matches the 3-bit opcode field.
   typedef enum logic [2:0] {
      LD  = 3'd0,
      ADD = 3'd1,
      AND = 3'd2,
      OR  = 3'd3,
      XOR = 3'd4,
      ROR = 3'd5,
      ADC = 3'd6,
      STO = 3'd7
   } opcode_t;

   // Predicate bits. A set flag bit means that flag is not tested.
   localparam int PRED_C  = 15;
   localparam int PRED_Z  = 14;
   localparam int PINVERT = 13;

   localparam int LONG_BIT     = 12;        // A second operand word follows.
   localparam int INDIRECT_BIT = 11;        // The operand is fetched from memory.

   localparam int OPCODE_LSB = 8;           // Low bit of the opcode field.
   localparam int SRC_LSB    = 4;           // Low bit of the source register field.
   localparam int DST_LSB    = 0;           // Low bit of the destination register field.

endpackage

/* hdl/opc5_control.sv */
`timescale 1ns/1ps

module opc5_control
   import opc5_cpu_pkg::*;
   import opc5_isa_pkg::*;
(
   input  logic   clk,
   input  logic   reset_b,
   input  word_t  read_data,
   input  word_t  instr,
   input  logic   carry_flag,
   input  logic   zero_flag,
   output state_t state,
   output logic   reg_read_sel,
   output logic   use_operand_address,
   output logic   reg_we,
   output logic   pc_load,
   output logic   flag_we,
   output logic   rnw
);

   logic      predicate_d;
   logic      predicate_q;
   logic      sto_d;
   logic      sto_q;
   logic      skip_ea;
   opcode_t   fetched_opcode;
   reg_addr_t src_field;
   reg_addr_t dst_field;

   assign predicate_d = read_data[PINVERT] ^
                        ((read_data[PRED_C] | carry_flag) & (read_data[PRED_Z] | zero_flag));
   assign fetched_opcode = opcode_t'(read_data[OPCODE_LSB +: $bits(opcode_t)]);
   assign sto_d          = (fetched_opcode == STO);
   assign src_field      = instr[SRC_LSB +: $bits(reg_addr_t)];
   assign dst_field      = instr[DST_LSB +: $bits(reg_addr_t)];
   // With r0 as source the immediate word is already the operand.
   assign skip_ea        = (src_field == '0) && !instr[INDIRECT_BIT] && !sto_q;

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         predicate_q <= 1'b0;
         sto_q       <= 1'b0;
      end
      else if (state == FETCH0)
      begin
         predicate_q <= predicate_d;                    // Held until the next FETCH0.
         sto_q       <= sto_d;
      end
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         state <= FETCH0;
      end
      else
      begin
         case (state)
            FETCH0 : state <= read_data[LONG_BIT] ? FETCH1 : (predicate_d ? EA_ED : FETCH0);
            FETCH1 : state <= !predicate_q ? FETCH0 : (skip_ea ? EXEC : EA_ED);
            EA_ED  : state <= instr[INDIRECT_BIT] ? RDMEM : (sto_q ? WRMEM : EXEC);
            RDMEM  : state <= EXEC;
            default: state <= FETCH0;                   // EXEC and WRMEM end the instruction.
         endcase
      end
   end

   assign reg_read_sel        = (state == EXEC) || (state == WRMEM);
   assign use_operand_address = (state == RDMEM) || (state == WRMEM);
   assign reg_we              = (state == EXEC) && (dst_field != PC_REG);
   assign pc_load             = (state == EXEC) && (dst_field == PC_REG);
   assign flag_we             = (state == EXEC);
   assign rnw                 = (state != WRMEM);

endmodule

/* hdl/opc5_fetch.sv */
`timescale 1ns/1ps

module opc5_fetch
   import opc5_cpu_pkg::*;
(
   input  logic   clk,
   input  logic   reset_b,
   input  state_t state,
   input  word_t  read_data,
   input  word_t  result,
   input  logic   pc_load,
   input  word_t  operand_value,
   input  logic   use_operand_address,
   output word_t  instr,
   output word_t  pc,
   output word_t  address
);

   logic pc_step;

   assign pc_step = (state == FETCH0) || (state == FETCH1);

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         pc <= '0;
      end
      else if (pc_step)
      begin
         pc <= pc + 1'b1;                    // Steps past the instruction and its operand word.
      end
      else if (pc_load)
      begin
         pc <= result;
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == FETCH0)
      begin
         instr <= read_data;
      end
   end

   // Data accesses use the effective address; everything else fetches at the PC.
   assign address = use_operand_address ? operand_value : pc;

endmodule

/* hdl/opc5_regfile.sv */
`timescale 1ns/1ps

module opc5_regfile
   import opc5_cpu_pkg::*;
   import opc5_isa_pkg::*;
(
   input  logic  clk,
   input  logic  reg_read_sel,
   input  word_t instr,
   input  word_t pc,
   input  logic  reg_we,
   input  word_t write_data,
   output word_t reg_data
);

   word_t     regs [REG_COUNT];
   reg_addr_t read_addr;
   reg_addr_t write_addr;

   assign write_addr = instr[DST_LSB +: $bits(reg_addr_t)];
   assign read_addr  = reg_read_sel ? write_addr : instr[SRC_LSB +: $bits(reg_addr_t)];

   always_comb
   begin
      if (read_addr == PC_REG)
         reg_data = pc;
      else if (read_addr == '0)
         reg_data = '0;                      // r0 always reads as zero.
      else
         reg_data = regs[read_addr];
   end

   always_ff @(posedge clk)
   begin
      if (reg_we)
      begin
         regs[write_addr] <= write_data;     // Control never raises reg_we for r15.
      end
   end

endmodule

/* hdl/opc5_alu.sv */
`timescale 1ns/1ps

module opc5_alu
   import opc5_cpu_pkg::*;
   import opc5_isa_pkg::*;
(
   input  logic    clk,
   input  logic    reset_b,
   input  opcode_t opcode,
   input  word_t   reg_data,
   input  word_t   operand_value,
   input  logic    flag_we,
   output word_t   result,
   output logic    carry_flag,
   output logic    zero_flag
);

   logic carry_next;
   logic carry_in;

   assign carry_in = carry_flag && (opcode == ADC);

   always_comb
   begin
      carry_next = carry_flag;
      result     = operand_value;
      case (opcode)
         LD, STO : result = operand_value;
         ADD, ADC: {carry_next, result} = {1'b0, reg_data} + {1'b0, operand_value}
                                          + {{WORD_BITS{1'b0}}, carry_in};
         AND     : result = reg_data & operand_value;
         OR      : result = reg_data | operand_value;
         XOR     : result = reg_data ^ operand_value;
         ROR     : {result, carry_next} = {carry_flag, operand_value};  // Old carry enters bit 15.
         default : result = operand_value;
      endcase
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         carry_flag <= 1'b0;
         zero_flag  <= 1'b0;
      end
      else if (flag_we)
      begin
         carry_flag <= carry_next;
         zero_flag  <= (result == '0);
      end
   end

endmodule

/* hdl/opc5_operand_reg.sv */
`timescale 1ns/1ps

module opc5_operand_reg
   import opc5_cpu_pkg::*;
(
   input  logic   clk,
   input  state_t state,
   input  word_t  read_data,
   input  word_t  reg_data,
   output word_t  operand_value
);

   always_ff @(posedge clk)
   begin
      case (state)
         FETCH0:
         begin
            operand_value <= '0;                         // A one-word instruction has no offset.
         end
         FETCH1, RDMEM:
         begin
            operand_value <= read_data;
         end
         EA_ED:
         begin
            operand_value <= operand_value + reg_data;   // Source register plus offset.
         end
         default:
         begin
            operand_value <= operand_value;
         end
      endcase
   end

endmodule

/* hdl/opc5_memory.sv */
`timescale 1ns/1ps

module opc5_memory
   import opc5_cpu_pkg::*;
(
   input  logic  clk,
   input  word_t address,
   input  word_t write_data,
   input  logic  rnw,
   input  logic  load_en,
   input  word_t load_address,
   input  word_t load_data,
   output word_t read_data
);

   word_t                mem [MEM_WORDS];
   logic [ADDR_BITS-1:0] cpu_index;
   logic [ADDR_BITS-1:0] load_index;

   // Addresses wrap at the memory size.
   assign cpu_index  = address[ADDR_BITS-1:0];
   assign load_index = load_address[ADDR_BITS-1:0];

   assign read_data = mem[cpu_index];

   always_ff @(posedge clk)
   begin
      if (load_en)
      begin
         mem[load_index] <= load_data;           // Only used while the core is in reset.
      end
      else if (!rnw)
      begin
         mem[cpu_index] <= write_data;
      end
   end

endmodule

/* hdl/opc5_system.sv */
`timescale 1ns/1ps

module opc5_system
   import opc5_cpu_pkg::*;
   import opc5_isa_pkg::*;
(
   input  logic  clk,
   input  logic  reset_b,
   input  logic  load_en,
   input  word_t load_address,
   input  word_t load_data,
   output word_t address,
   output word_t write_data,
   output logic  rnw
);

   state_t  state;
   word_t   read_data;
   word_t   instr;
   word_t   pc;
   word_t   reg_data;
   word_t   result;
   word_t   operand_value;
   opcode_t opcode;
   logic    reg_read_sel;
   logic    use_operand_address;
   logic    reg_we;
   logic    pc_load;
   logic    flag_we;
   logic    carry_flag;
   logic    zero_flag;

   assign opcode     = opcode_t'(instr[OPCODE_LSB +: $bits(opcode_t)]);
   assign write_data = reg_data;

   opc5_control control_i (
      .clk                 (clk),
      .reset_b             (reset_b),
      .read_data           (read_data),
      .instr               (instr),
      .carry_flag          (carry_flag),
      .zero_flag           (zero_flag),
      .state               (state),
      .reg_read_sel        (reg_read_sel),
      .use_operand_address (use_operand_address),
      .reg_we              (reg_we),
      .pc_load             (pc_load),
      .flag_we             (flag_we),
      .rnw                 (rnw)
   );

   opc5_fetch fetch_i (
      .clk                 (clk),
      .reset_b             (reset_b),
      .state               (state),
      .read_data           (read_data),
      .result              (result),
      .pc_load             (pc_load),
      .operand_value       (operand_value),
      .use_operand_address (use_operand_address),
      .instr               (instr),
      .pc                  (pc),
      .address             (address)
   );

   opc5_regfile regfile_i (
      .clk          (clk),
      .reg_read_sel (reg_read_sel),
      .instr        (instr),
      .pc           (pc),
      .reg_we       (reg_we),
      .write_data   (result),
      .reg_data     (reg_data)
   );

   opc5_alu alu_i (
      .clk           (clk),
      .reset_b       (reset_b),
      .opcode        (opcode),
      .reg_data      (reg_data),
      .operand_value (operand_value),
      .flag_we       (flag_we),
      .result        (result),
      .carry_flag    (carry_flag),
      .zero_flag     (zero_flag)
   );

   opc5_operand_reg operand_reg_i (
      .clk           (clk),
      .state         (state),
      .read_data     (read_data),
      .reg_data      (reg_data),
      .operand_value (operand_value)
   );

   opc5_memory memory_i (
      .clk          (clk),
      .address      (address),
      .write_data   (reg_data),
      .rnw          (rnw),
      .load_en      (load_en),
      .load_address (load_address),
      .load_data    (load_data),
      .read_data    (read_data)
   );

endmodule

/* tests/opc5_system_tb.sv */
`timescale 1ns/1ps

module opc5_system_tb
   import opc5_cpu_pkg::*;
();

   localparam int RESET_CYCLES  = 8;
   localparam int SETTLE_CYCLES = 16;                    // Several turns of the final self-jump.

   logic  clk          = 1'b0;
   logic  reset_b      = 1'b0;
   logic  load_en      = 1'b0;
   word_t load_address = '0;
   word_t load_data    = '0;
   word_t address;
   word_t write_data;
   logic  rnw;

   word_t prog_addr_q[$];
   word_t prog_data_q[$];
   int    prog_words_q[$];
   int    prog_writes_q[$];
   word_t exp_addr_q[$];
   word_t exp_data_q[$];
   int    pending;
   int    cycle_limit;
   int    cycle_count = 0;

   opc5_system dut_i (
      .clk          (clk),
      .reset_b      (reset_b),
      .load_en      (load_en),
      .load_address (load_address),
      .load_data    (load_data),
      .address      (address),
      .write_data   (write_data),
      .rnw          (rnw)
   );

   always #50 clk = ~clk;

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display(">>> FAIL");
      $fatal(1, "Simulation stopped.");
   endtask

   task automatic check_address(input word_t actual, input word_t expected);
      if (actual !== expected)
      begin
         $display("Error at %0t ns: address = %h, expected %h", $time, actual, expected);
         abort_run("A memory write went to the wrong address.");
      end
   endtask

   task automatic check_data(input word_t actual, input word_t expected);
      if (actual !== expected)
      begin
         $display("Error at %0t ns: write_data = %h, expected %h", $time, actual, expected);
         abort_run("A memory write carried the wrong data.");
      end
   endtask

   task automatic read_vectors();
      int    fd;
      int    fields;
      int    words;
      int    writes;
      string line;
      byte   kind;
      word_t addr_field;
      word_t data_field;
      fd = $fopen("tests/opc5_system_vectors.txt", "r");
      if (fd == 0)
         abort_run("The vector file tests/opc5_system_vectors.txt could not be opened.");
      words  = 0;
      writes = 0;
      while ($fgets(line, fd) > 0)
      begin
         kind = line.getc(0);
         if (kind == "P" || kind == "W")
         begin
            fields = $sscanf(line.substr(1, line.len() - 1), "%h %h", addr_field, data_field);
            if (fields != 2)
               abort_run({"A vector line could not be read: ", line});
            if (kind == "P")
            begin
               prog_addr_q.push_back(addr_field);
               prog_data_q.push_back(data_field);
               words++;
            end
            else
            begin
               exp_addr_q.push_back(addr_field);
               exp_data_q.push_back(data_field);
               writes++;
            end
         end
         else if (kind == "T")
         begin
            prog_words_q.push_back(words);             // One entry per program.
            prog_writes_q.push_back(writes);
            words  = 0;
            writes = 0;
         end
      end
      $fclose(fd);
   endtask

   task automatic watch_cycle();
      @(negedge clk);
      if (!rnw)
      begin
         if (pending == 0)
            abort_run($sformatf("An unexpected memory write to %h happened at %0t ns.",
                                address, $time));
         check_address(address, exp_addr_q.pop_front());
         check_data(write_data, exp_data_q.pop_front());
         pending--;
      end
   endtask

   task automatic run_program(input int first, input int count, input int writes);
      @(posedge clk);
      reset_b <= 1'b0;
      for (int i = 0; i < count; i++)
      begin
         @(posedge clk);
         load_en      <= 1'b1;
         load_address <= prog_addr_q[first + i];
         load_data    <= prog_data_q[first + i];
      end
      @(posedge clk);
      load_en <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset_b <= 1'b1;
      pending = writes;
      while (pending > 0)
         watch_cycle();
      repeat (SETTLE_CYCLES)
         watch_cycle();                                 // Any write here is a failure.
   endtask

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit)
         abort_run($sformatf("Timeout after %0d cycles with %0d writes still expected.",
                             cycle_count, exp_addr_q.size()));
   end

   initial
   begin
      int first;
      read_vectors();
      cycle_limit = 5 * prog_addr_q.size() + 200;
      first       = 0;
      for (int p = 0; p < prog_words_q.size(); p++)
      begin
         run_program(first, prog_words_q[p], prog_writes_q[p]);
         first += prog_words_q[p];
      end
      if (exp_addr_q.size() == 0 && prog_words_q.size() > 0)
      begin
         $display(">>> PASS");
         $finish;
      end
      else
      begin
         abort_run("The vectors held no program or expected writes were never reached.");
      end
   end

endmodule

/* opc5_system.f */
hdl/opc5_cpu_pkg.sv
hdl/opc5_isa_pkg.sv
hdl/opc5_control.sv
hdl/opc5_fetch.sv
hdl/opc5_regfile.sv
hdl/opc5_alu.sv
hdl/opc5_operand_reg.sv
hdl/opc5_memory.sv
hdl/opc5_system.sv
tests/opc5_system_tb.sv

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -sv --top-module opc5_system_tb -f opc5_system.f -o opc5_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed."
   exit 1
fi

output=$(./obj_dir/opc5_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status."
   exit 1
fi

if echo "$output" | grep -q '^>>> PASS$'; then
   exit 0
fi
echo "Simulation finished without the pass message."
exit 1

/* tests/opc5_system_vectors.txt */
# Columns: kind, address, data (hex). P is a program word, W an expected write in order.
# T ends a program. Text after the data column is a note.
P 0000 D001  LD r1, r0, 0xF000
P 0001 F000
P 0002 D701  STO r1, r0, 0x0100
P 0003 0100
P 0004 D101  ADD r1, r0, 0x2345 sets carry
P 0005 2345
P 0006 D004  LD r4, r0, 0x0101
P 0007 0101
P 0008 C741  STO r1, r4
P 0009 D601  ADC r1, r0, 0xF000 sets carry
P 000A F000
P 000B C741  STO r1, r4
P 000C D201  AND r1, r0, 0x0FF0
P 000D 0FF0
P 000E C741  STO r1, r4
P 000F D301  OR r1, r0, 0xA00A
P 0010 A00A
P 0011 C741  STO r1, r4
P 0012 D401  XOR r1, r0, 0xFFFF
P 0013 FFFF
P 0014 C741  STO r1, r4
P 0015 C512  ROR r2, r1
P 0016 C742  STO r2, r4
P 0017 C003  LD r3, r0
P 0018 C603  ADC r3, r0
P 0019 C743  STO r3, r4
P 001A D00F  LD r15, r0, 0x001A
P 001B 001A
W 0100 F000
W 0101 1345
W 0101 0346
W 0101 0340
W 0101 A34A
W 0101 5CB5
W 0101 AE5A
W 0101 0001
T
P 0000 D001  LD r1, r0, 0x00C3
P 0001 00C3
P 0002 D701  STO r1, r0, 0x0140
P 0003 0140
P 0004 C002  LD r2, r0 sets zero
P 0005 9701  STO on zero, taken
P 0006 0141
P 0007 5701  STO on carry, skipped
P 0008 0142
P 0009 7701  STO on no carry, taken
P 000A 0143
P 000B D813  LD r3, [r1 + 0x007D]
P 000C 007D
P 000D D703  STO r3, r0, 0x0144
P 000E 0144
P 000F D00F  LD r15, r0, 0x0012
P 0010 0012
P 0011 C711  STO r1, r1, jumped over
P 0012 D00F  LD r15, r0, 0x0012
P 0013 0012
W 0140 00C3
W 0141 00C3
W 0143 00C3
W 0144 00C3
T
